// ==== common/bridge_params.svh ====
// --------------------
// board constants, register map and bus response codes
// --------------------
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// ethernet side ports merged onto the link
`define BRIDGE_ETHCOUNT    4

// scratch words for bus testing
`define BRIDGE_TEST_COUNT  4

// fixed firmware id word
`define BRIDGE_FW_DATE     32'hF1A5_0C01

// --------------------
// register byte offsets
`define REG_FW_DATE        8'h00   // ro
`define REG_LINK           8'h04   // ro
`define REG_ETH_MASK       8'h08   // rw
`define REG_PHY_RST        8'h0C   // rw
`define REG_MDIO           8'h10   // rw, bit 3 ro pin input
`define REG_DROP_CNT       8'h14   // ro
`define REG_TEST_BASE      8'h20   // rw, consecutive words

// --------------------
// axi response codes
`define AXIL_RESP_OKAY     2'b00
`define AXIL_RESP_SLVERR   2'b10

`endif

// ==== common/bridge_pkg.sv ====
// --------------------
// shared vector types and mux state encoding
// --------------------
`include "bridge_params.svh"

package bridge_pkg;

    // --------------------
    // register access
    typedef logic [7:0]  reg_addr_t;   // byte address
    typedef logic [31:0] reg_data_t;
    typedef logic [1:0]  axil_resp_t;

    // --------------------
    // port selection
    typedef logic [$clog2(`BRIDGE_ETHCOUNT)-1:0] port_sel_t;
    typedef logic [`BRIDGE_ETHCOUNT-1:0]         port_mask_t;  // one bit per port

    // --------------------
    // stream payload
    typedef logic [31:0] beat_data_t;
    typedef logic [3:0]  beat_keep_t;  // byte enables, not interpreted
    typedef logic [15:0] drop_cnt_t;   // wraps

    // frame mux fsm
    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_PASS,
        MUX_DROP
    } mux_state_t;

endpackage

// ==== common/reg_if.sv ====
// --------------------
// single cycle register access between bus slave and bank
// --------------------
`timescale 1ns/1ps

interface reg_if;
    import bridge_pkg::*;

    // write side, applied on the edge where wr_en is high
    logic       wr_en;
    reg_addr_t  wr_addr;
    reg_data_t  wr_data;

    // read side, answered combinationally
    reg_addr_t  rd_addr;
    reg_data_t  rd_data;

    axil_resp_t resp;  // for wr_addr while wr_en, else for rd_addr

    modport slave (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  rd_data,
        input  resp
    );

    modport bank (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data,
        output resp
    );

endinterface

// ==== hw/bridge_top.sv ====
// --------------------
// top level, bus front end, register bank and frame mux
// --------------------
`timescale 1ns/1ps
`include "bridge_params.svh"

module bridge_top (
    input  logic                   clk125M,
    input  logic                   rst_n_i,

    // axi4-lite
    input  bridge_pkg::reg_addr_t  awaddr_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  bridge_pkg::reg_data_t  wdata_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    output bridge_pkg::axil_resp_t bresp_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,
    input  bridge_pkg::reg_addr_t  araddr_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    output bridge_pkg::reg_data_t  rdata_o,
    output bridge_pkg::axil_resp_t rresp_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,

    // port streams and select pins
    input  bridge_pkg::port_sel_t  sel_i,
    input  bridge_pkg::beat_data_t s_tdata_i [`BRIDGE_ETHCOUNT],
    input  bridge_pkg::beat_keep_t s_tkeep_i [`BRIDGE_ETHCOUNT],
    input  bridge_pkg::port_mask_t s_tvalid_i,
    input  bridge_pkg::port_mask_t s_tlast_i,
    output bridge_pkg::port_mask_t s_tready_o,

    // link stream
    output bridge_pkg::beat_data_t m_tdata_o,
    output bridge_pkg::beat_keep_t m_tkeep_o,
    output logic                   m_tvalid_o,
    output logic                   m_tlast_o,
    input  logic                   m_tready_i,

    // board pins
    input  bridge_pkg::port_mask_t link_i,
    input  logic                   mdio_i,
    output bridge_pkg::port_mask_t eth_phy_rst_o,
    output logic                   mdio_mdc_o,
    output logic                   mdio_data_o,
    output logic                   mdio_oe_o
);
    import bridge_pkg::*;

    port_mask_t eth_mask;   // bank to mux
    drop_cnt_t  drop_cnt;   // mux back to bank

    reg_if u_regs ();

    axil_slave u_axil (
        .clk125M   (clk125M),
        .rst_n_i   (rst_n_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .regs      (u_regs.slave)
    );

    reg_bank u_bank (
        .clk125M       (clk125M),
        .rst_n_i       (rst_n_i),
        .regs          (u_regs.bank),
        .link_i        (link_i),
        .mdio_i        (mdio_i),
        .drop_cnt_i    (drop_cnt),
        .eth_mask_o    (eth_mask),
        .eth_phy_rst_o (eth_phy_rst_o),
        .mdio_mdc_o    (mdio_mdc_o),
        .mdio_data_o   (mdio_data_o),
        .mdio_oe_o     (mdio_oe_o)
    );

    frame_tx_mux u_mux (
        .clk125M    (clk125M),
        .rst_n_i    (rst_n_i),
        .sel_i      (sel_i),
        .eth_mask_i (eth_mask),
        .s_tdata_i  (s_tdata_i),
        .s_tkeep_i  (s_tkeep_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tlast_i  (s_tlast_i),
        .s_tready_o (s_tready_o),
        .m_tdata_o  (m_tdata_o),
        .m_tkeep_o  (m_tkeep_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tlast_o  (m_tlast_o),
        .m_tready_i (m_tready_i),
        .drop_cnt_o (drop_cnt)
    );

endmodule

// ==== hw/regs/axil_slave.sv ====
// --------------------
// axi4-lite slave, turns bus transfers into register accesses
// --------------------
`timescale 1ns/1ps

module axil_slave (
    input  logic                   clk125M,
    input  logic                   rst_n_i,

    // write address and data
    input  bridge_pkg::reg_addr_t  awaddr_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  bridge_pkg::reg_data_t  wdata_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,

    // write response
    output bridge_pkg::axil_resp_t bresp_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,

    // read address
    input  bridge_pkg::reg_addr_t  araddr_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,

    // read data
    output bridge_pkg::reg_data_t  rdata_o,
    output bridge_pkg::axil_resp_t rresp_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,

    reg_if.slave                   regs
);
    import bridge_pkg::*;

    logic wr_accept;
    logic rd_accept;

    // --------------------
    // handshakes
    // address and data taken together, only with no response waiting
    assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;

    // bank has one resp line, so a write in the same cycle wins
    assign arready_o = !rvalid_o && !wr_accept;
    assign rd_accept = arvalid_i && arready_o;

    // bank access straight from the bus
    assign regs.wr_en   = wr_accept;
    assign regs.wr_addr = awaddr_i;
    assign regs.wr_data = wdata_i;
    assign regs.rd_addr = araddr_i;

    // --------------------
    // response valids
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end

            if (rd_accept) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // response payload, held while valid is up
    always_ff @(posedge clk125M) begin
        if (wr_accept) begin
            bresp_o <= regs.resp;
        end
        if (rd_accept) begin
            rdata_o <= regs.rd_data;
            rresp_o <= regs.resp;
        end
    end

    // --------------------
    // responses wait for the master
    a_bvalid_hold : assert property (
        @(posedge clk125M) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o)
    );

    a_rvalid_hold : assert property (
        @(posedge clk125M) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o)
    );

endmodule

// ==== hw/regs/reg_bank.sv ====
// --------------------
// control and status registers with address decode
// --------------------
`timescale 1ns/1ps
`include "bridge_params.svh"

module reg_bank (
    input  logic                   clk125M,
    input  logic                   rst_n_i,

    reg_if.bank                    regs,

    input  bridge_pkg::port_mask_t link_i,
    input  logic                   mdio_i,
    input  bridge_pkg::drop_cnt_t  drop_cnt_i,

    output bridge_pkg::port_mask_t eth_mask_o,
    output bridge_pkg::port_mask_t eth_phy_rst_o,
    output logic                   mdio_mdc_o,
    output logic                   mdio_data_o,
    output logic                   mdio_oe_o
);
    import bridge_pkg::*;

    localparam int TEST_IW = $clog2(`BRIDGE_TEST_COUNT);

    reg_data_t  test_q [`BRIDGE_TEST_COUNT];
    port_mask_t eth_mask_q;
    port_mask_t phy_rst_q;
    logic       mdc_q;
    logic       mdo_q;
    logic       moe_q;

    logic       rd_hit;
    logic       wr_ok;

    // word inside the scratch window
    function automatic logic is_test(reg_addr_t a);
        return (a >= `REG_TEST_BASE) &&
               (a < `REG_TEST_BASE + 4 * `BRIDGE_TEST_COUNT) &&
               (a[1:0] == 2'b00);
    endfunction

    function automatic logic [TEST_IW-1:0] test_idx(reg_addr_t a);
        return TEST_IW'((a - `REG_TEST_BASE) >> 2);
    endfunction

    // --------------------
    // writable registers
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            eth_mask_q <= '0;
            phy_rst_q  <= '0;
            mdc_q      <= 1'b0;
            mdo_q      <= 1'b0;
            moe_q      <= 1'b0;
            for (int i = 0; i < `BRIDGE_TEST_COUNT; i++) begin
                test_q[i] <= '0;
            end
        end else if (regs.wr_en) begin
            case (regs.wr_addr)
                `REG_ETH_MASK: eth_mask_q <= regs.wr_data[`BRIDGE_ETHCOUNT-1:0];
                `REG_PHY_RST:  phy_rst_q  <= regs.wr_data[`BRIDGE_ETHCOUNT-1:0];
                `REG_MDIO: begin
                    mdc_q <= regs.wr_data[0];
                    mdo_q <= regs.wr_data[1];
                    moe_q <= regs.wr_data[2];  // bit 3 is the pin input
                end
                default: begin
                    if (is_test(regs.wr_addr)) begin
                        test_q[test_idx(regs.wr_addr)] <= regs.wr_data;
                    end
                end
            endcase
        end
    end

    // --------------------
    // read decode with zero for unmapped
    always_comb begin
        rd_hit       = 1'b1;
        regs.rd_data = '0;
        case (regs.rd_addr)
            `REG_FW_DATE:  regs.rd_data = `BRIDGE_FW_DATE;
            `REG_LINK:     regs.rd_data = reg_data_t'(link_i);
            `REG_ETH_MASK: regs.rd_data = reg_data_t'(eth_mask_q);
            `REG_PHY_RST:  regs.rd_data = reg_data_t'(phy_rst_q);
            `REG_MDIO:     regs.rd_data = reg_data_t'({mdio_i, moe_q, mdo_q, mdc_q});
            `REG_DROP_CNT: regs.rd_data = reg_data_t'(drop_cnt_i);
            default: begin
                rd_hit = is_test(regs.rd_addr);
                if (rd_hit) begin
                    regs.rd_data = test_q[test_idx(regs.rd_addr)];
                end
            end
        endcase
    end

    // read-only and unmapped writes are refused
    always_comb begin
        wr_ok = is_test(regs.wr_addr);
        case (regs.wr_addr)
            `REG_ETH_MASK, `REG_PHY_RST, `REG_MDIO: wr_ok = 1'b1;
            default: ;
        endcase
    end

    assign regs.resp = regs.wr_en ? (wr_ok  ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR)
                                  : (rd_hit ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR);

    // --------------------
    // outputs
    assign eth_mask_o    = eth_mask_q;
    assign eth_phy_rst_o = phy_rst_q;
    assign mdio_mdc_o    = mdc_q;
    assign mdio_data_o   = mdo_q;
    assign mdio_oe_o     = moe_q;

    a_wr_addr_known : assert property (
        @(posedge clk125M) disable iff (!rst_n_i)
        regs.wr_en |-> !$isunknown(regs.wr_addr)
    );

endmodule

// ==== hw/stream/frame_tx_mux.sv ====
// --------------------
// frame mux from the port streams onto the link stream
// --------------------
`timescale 1ns/1ps
`include "bridge_params.svh"

module frame_tx_mux (
    input  logic                   clk125M,
    input  logic                   rst_n_i,

    input  bridge_pkg::port_sel_t  sel_i,
    input  bridge_pkg::port_mask_t eth_mask_i,

    // port side
    input  bridge_pkg::beat_data_t s_tdata_i [`BRIDGE_ETHCOUNT],
    input  bridge_pkg::beat_keep_t s_tkeep_i [`BRIDGE_ETHCOUNT],
    input  bridge_pkg::port_mask_t s_tvalid_i,
    input  bridge_pkg::port_mask_t s_tlast_i,
    output bridge_pkg::port_mask_t s_tready_o,

    // link side
    output bridge_pkg::beat_data_t m_tdata_o,
    output bridge_pkg::beat_keep_t m_tkeep_o,
    output logic                   m_tvalid_o,
    output logic                   m_tlast_o,
    input  logic                   m_tready_i,

    output bridge_pkg::drop_cnt_t  drop_cnt_o
);
    import bridge_pkg::*;

    mux_state_t state_q;
    port_sel_t  sel_q;     // granted port for the current frame
    drop_cnt_t  drop_q;

    logic cur_valid;
    logic cur_last;

    assign cur_valid = s_tvalid_i[sel_q];
    assign cur_last  = s_tlast_i[sel_q];

    // --------------------
    // grant fsm
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MUX_IDLE;
            sel_q   <= '0;
            drop_q  <= '0;
        end else begin
            case (state_q)
                MUX_IDLE: begin
                    // select pins only looked at between frames
                    if (s_tvalid_i[sel_i]) begin
                        sel_q   <= sel_i;
                        state_q <= eth_mask_i[sel_i] ? MUX_PASS : MUX_DROP;
                    end
                end
                MUX_PASS: begin
                    if (cur_valid && m_tready_i && cur_last) begin
                        state_q <= MUX_IDLE;
                    end
                end
                MUX_DROP: begin
                    if (cur_valid && cur_last) begin
                        state_q <= MUX_IDLE;
                        drop_q  <= drop_q + 1'b1;  // wraps
                    end
                end
                default: state_q <= MUX_IDLE;
            endcase
        end
    end

    // --------------------
    // zero cycle data path
    always_comb begin
        s_tready_o = '0;
        m_tvalid_o = 1'b0;
        m_tlast_o  = 1'b0;
        m_tdata_o  = s_tdata_i[sel_q];
        m_tkeep_o  = s_tkeep_i[sel_q];
        case (state_q)
            MUX_PASS: begin
                s_tready_o[sel_q] = m_tready_i;
                m_tvalid_o        = cur_valid;
                m_tlast_o         = cur_last;
            end
            MUX_DROP: begin
                s_tready_o[sel_q] = 1'b1;  // sink the frame
            end
            default: ;
        endcase
    end

    assign drop_cnt_o = drop_q;

    // --------------------
    a_one_ready : assert property (
        @(posedge clk125M) disable iff (!rst_n_i)
        $onehot0(s_tready_o)
    );

    a_valid_in_pass : assert property (
        @(posedge clk125M) disable iff (!rst_n_i)
        m_tvalid_o |-> state_q == MUX_PASS
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_bridge -o tb_bridge &&
./obj_dir/tb_bridge | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }

// ==== sim/bridge_checker.sv ====
// --------------------
// bus response, link beat and pin checker
// --------------------
`timescale 1ns/1ps

module bridge_checker (
    input  logic                   clk125M,
    input  logic                   rst_n_i,
    input  bridge_pkg::axil_resp_t bresp_i,
    input  logic                   bvalid_i,
    input  logic                   bready_i,
    input  bridge_pkg::reg_data_t  rdata_i,
    input  bridge_pkg::axil_resp_t rresp_i,
    input  logic                   rvalid_i,
    input  logic                   rready_i,
    input  bridge_pkg::beat_data_t m_tdata_i,
    input  bridge_pkg::beat_keep_t m_tkeep_i,
    input  logic                   m_tvalid_i,
    input  logic                   m_tlast_i,
    input  logic                   m_tready_i,
    input  bridge_pkg::port_mask_t phy_rst_i,
    input  logic                   mdc_i,
    input  logic                   mdo_i,
    input  logic                   moe_i
);
    import bridge_pkg::*;

    int errors = 0;

    // expected values, queued by the driver ahead of time
    axil_resp_t exp_bresp [$];
    reg_data_t  exp_rdata [$];
    axil_resp_t exp_rresp [$];
    beat_data_t exp_data  [$];
    beat_keep_t exp_keep  [$];
    logic       exp_last  [$];

    function automatic void compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endfunction

    function automatic void expect_write(axil_resp_t resp);
        exp_bresp.push_back(resp);
    endfunction

    function automatic void expect_read(reg_data_t data, axil_resp_t resp);
        exp_rdata.push_back(data);
        exp_rresp.push_back(resp);
    endfunction

    function automatic void expect_beat(beat_data_t data, beat_keep_t keep, logic last);
        exp_data.push_back(data);
        exp_keep.push_back(keep);
        exp_last.push_back(last);
    endfunction

    // register driven pins, called at a stable point
    function automatic void check_pins(port_mask_t phy, logic mdc, logic mdo, logic moe);
        compare("eth_phy_rst_o", 32'(phy_rst_i), 32'(phy));
        compare("mdio_mdc_o", 32'(mdc_i), 32'(mdc));
        compare("mdio_data_o", 32'(mdo_i), 32'(mdo));
        compare("mdio_oe_o", 32'(moe_i), 32'(moe));
    endfunction

    function automatic int pending();
        return exp_bresp.size() + exp_rdata.size() + exp_data.size();
    endfunction

    function automatic void report_leftovers();
        if (exp_bresp.size() != 0) begin
            $display("%0d write responses never arrived", exp_bresp.size());
            errors++;
        end
        if (exp_rdata.size() != 0) begin
            $display("%0d read responses never arrived", exp_rdata.size());
            errors++;
        end
        if (exp_data.size() != 0) begin
            $display("%0d link beats missing", exp_data.size());
            errors++;
        end
    endfunction

    // --------------------
    // sampled mid cycle, inputs settled
    always @(negedge clk125M) begin
        if (rst_n_i) begin
            if (bvalid_i && bready_i) begin
                if (exp_bresp.size() == 0) begin
                    $display("write response arrived with none expected");
                    errors++;
                end else begin
                    compare("bresp_o", 32'(bresp_i), 32'(exp_bresp.pop_front()));
                end
            end
            if (rvalid_i && rready_i) begin
                if (exp_rdata.size() == 0) begin
                    $display("read response arrived with none expected");
                    errors++;
                end else begin
                    compare("rdata_o", rdata_i, exp_rdata.pop_front());
                    compare("rresp_o", 32'(rresp_i), 32'(exp_rresp.pop_front()));
                end
            end
            if (m_tvalid_i && m_tready_i) begin
                if (exp_data.size() == 0) begin
                    $display("extra beat on the link, data %h", m_tdata_i);
                    errors++;
                end else begin
                    compare("m_tdata_o", m_tdata_i, exp_data.pop_front());
                    compare("m_tkeep_o", 32'(m_tkeep_i), 32'(exp_keep.pop_front()));
                    compare("m_tlast_o", 32'(m_tlast_i), 32'(exp_last.pop_front()));
                end
            end
        end
    end

endmodule

// ==== sim/bridge_golden.txt ====
# W addr data resp | R addr rdata rresp | P link mdio | O phy_rst mdc mdo moe
# F port sel beats fwd (1 forward, 0 drop); all hex, resp 0 okay, 2 slverr
R 00 F1A50C01 0
W 20 DEADBEEF 0
W 24 12345678 0
W 28 A5A5A5A5 0
W 2C 0000FFFF 0
R 20 DEADBEEF 0
R 24 12345678 0
R 28 A5A5A5A5 0
R 2C 0000FFFF 0
W 0C 0000000A 0
R 0C 0000000A 0
O A 0 0 0
W 10 00000005 0
O A 1 0 1
P 6 1
R 04 00000006 0
R 10 0000000D 0
W 10 0000000A 0
P 9 0
R 10 00000002 0
R 04 00000009 0
O A 0 1 0
R 18 00000000 2
R 22 00000000 2
R 40 00000000 2
W 00 11111111 2
W 04 22222222 2
W 14 33333333 2
W 30 44444444 2
R 00 F1A50C01 0
R 04 00000009 0
R 14 00000000 0
R 2C 0000FFFF 0
W 08 00000005 0
R 08 00000005 0
F 0 0 5 1
F 2 2 3 1
F 1 1 4 0
F 3 3 2 0
R 14 00000002 0
F 1 1 1 0
F 0 0 7 1
R 14 00000003 0
W 0C 00000000 0
O 0 0 1 0

// ==== sim/tb_bridge.sv ====
// --------------------
// testbench top, golden file driver, link back-pressure and run limit
// --------------------
`timescale 1ns/1ps
`include "bridge_params.svh"

module tb_bridge;
    import bridge_pkg::*;

    logic       clk125M;
    logic       rst_n_i;
    reg_addr_t  awaddr_i;
    logic       awvalid_i;
    logic       awready_o;
    reg_data_t  wdata_i;
    logic       wvalid_i;
    logic       wready_o;
    axil_resp_t bresp_o;
    logic       bvalid_o;
    logic       bready_i;
    reg_addr_t  araddr_i;
    logic       arvalid_i;
    logic       arready_o;
    reg_data_t  rdata_o;
    axil_resp_t rresp_o;
    logic       rvalid_o;
    logic       rready_i;
    port_sel_t  sel_i;
    beat_data_t s_tdata_i [`BRIDGE_ETHCOUNT];
    beat_keep_t s_tkeep_i [`BRIDGE_ETHCOUNT];
    port_mask_t s_tvalid_i;
    port_mask_t s_tlast_i;
    port_mask_t s_tready_o;
    beat_data_t m_tdata_o;
    beat_keep_t m_tkeep_o;
    logic       m_tvalid_o;
    logic       m_tlast_o;
    logic       m_tready_i;
    port_mask_t link_i;
    logic       mdio_i;
    port_mask_t eth_phy_rst_o;
    logic       mdio_mdc_o;
    logic       mdio_data_o;
    logic       mdio_oe_o;

    // golden operations, one entry per file line
    byte         op_q [$];
    logic [31:0] f1_q [$];
    logic [31:0] f2_q [$];
    logic [31:0] f3_q [$];
    logic [31:0] f4_q [$];

    int          beat_total = 0;
    int          limit = 1000000;
    int          cycle_cnt = 0;
    int          drv_errors = 0;
    logic [15:0] lfsr_q;

    bridge_top DUT (
        .clk125M(clk125M), .rst_n_i(rst_n_i),
        .awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
        .wdata_i(wdata_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
        .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
        .araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
        .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
        .sel_i(sel_i), .s_tdata_i(s_tdata_i), .s_tkeep_i(s_tkeep_i),
        .s_tvalid_i(s_tvalid_i), .s_tlast_i(s_tlast_i), .s_tready_o(s_tready_o),
        .m_tdata_o(m_tdata_o), .m_tkeep_o(m_tkeep_o), .m_tvalid_o(m_tvalid_o),
        .m_tlast_o(m_tlast_o), .m_tready_i(m_tready_i),
        .link_i(link_i), .mdio_i(mdio_i), .eth_phy_rst_o(eth_phy_rst_o),
        .mdio_mdc_o(mdio_mdc_o), .mdio_data_o(mdio_data_o), .mdio_oe_o(mdio_oe_o)
    );

    bridge_checker chk (
        .clk125M(clk125M), .rst_n_i(rst_n_i),
        .bresp_i(bresp_o), .bvalid_i(bvalid_o), .bready_i(bready_i),
        .rdata_i(rdata_o), .rresp_i(rresp_o), .rvalid_i(rvalid_o), .rready_i(rready_i),
        .m_tdata_i(m_tdata_o), .m_tkeep_i(m_tkeep_o), .m_tvalid_i(m_tvalid_o),
        .m_tlast_i(m_tlast_o), .m_tready_i(m_tready_i),
        .phy_rst_i(eth_phy_rst_o), .mdc_i(mdio_mdc_o), .mdo_i(mdio_data_o),
        .moe_i(mdio_oe_o)
    );

    always #4 clk125M = ~clk125M;   // 8 ns

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return b;
    endfunction

    // --------------------
    // link back-pressure
    always @(posedge clk125M) begin
        #1;
        m_tready_i = next_bit();
    end

    // run limit
    always @(posedge clk125M) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("timeout, run stopped after %0d cycles", cycle_cnt);
            $display("errors: %0d checker, %0d driver", chk.errors, drv_errors);
            $display("test failed");
            $finish;
        end
    end

    // --------------------
    // bus and stream drivers, entered and left 1 ns after a rising edge
    task automatic write_reg(reg_addr_t addr, reg_data_t data);
        logic acc;
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        do begin
            @(negedge clk125M);
            acc = awready_o && wready_o;
            @(posedge clk125M);
            #1;
        end while (!acc);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
    endtask

    task automatic read_reg(reg_addr_t addr);
        logic acc;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        do begin
            @(negedge clk125M);
            acc = arready_o;
            @(posedge clk125M);
            #1;
        end while (!acc);
        arvalid_i = 1'b0;
    endtask

    task automatic send_frame(int port, int sel, int beats, logic fwd);
        beat_data_t data;
        logic       acc;
        sel_i = port_sel_t'(sel);
        for (int b = 0; b < beats; b++) begin
            data = beat_data_t'(port) * 32'h1000_0000 + beat_data_t'(b);
            if (fwd) begin
                chk.expect_beat(data, 4'hF, b == beats - 1);
            end
            s_tdata_i[port]  = data;
            s_tkeep_i[port]  = 4'hF;
            s_tvalid_i[port] = 1'b1;
            s_tlast_i[port]  = (b == beats - 1);
            do begin
                @(negedge clk125M);
                acc = s_tready_o[port];
                @(posedge clk125M);
                #1;
            end while (!acc);
        end
        s_tvalid_i[port] = 1'b0;
        s_tlast_i[port]  = 1'b0;
    endtask

    // --------------------
    // golden file
    task automatic load_golden(output logic ok);
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        ok = 1'b0;
        fd = $fopen("sim/bridge_golden.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#" && line[0] != "\n") begin
                    v1 = '0;
                    v2 = '0;
                    v3 = '0;
                    v4 = '0;
                    n = $sscanf(line, "%c %h %h %h %h", op, v1, v2, v3, v4);
                    op_q.push_back(op);
                    f1_q.push_back(v1);
                    f2_q.push_back(v2);
                    f3_q.push_back(v3);
                    f4_q.push_back(v4);
                    if (op == "F") begin
                        beat_total += int'(v3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_golden();
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": begin
                    chk.expect_write(f3_q[i][1:0]);
                    write_reg(f1_q[i][7:0], f2_q[i]);
                end
                "R": begin
                    chk.expect_read(f2_q[i], f3_q[i][1:0]);
                    read_reg(f1_q[i][7:0]);
                end
                "P": begin
                    link_i = f1_q[i][3:0];
                    mdio_i = f2_q[i][0];
                    @(posedge clk125M);
                    #1;
                end
                "O": begin
                    @(negedge clk125M);
                    chk.check_pins(f1_q[i][3:0], f2_q[i][0], f3_q[i][0], f4_q[i][0]);
                    @(posedge clk125M);
                    #1;
                end
                "F": send_frame(int'(f1_q[i]), int'(f2_q[i]), int'(f3_q[i]), f4_q[i][0]);
                default: begin
                    $display("golden entry %0d has an unknown operation", i);
                    drv_errors++;
                end
            endcase
        end
    endtask

    task automatic finish_run();
        int total;
        for (int k = 0; k < 20 && chk.pending() != 0; k++) begin
            @(posedge clk125M);   // let the last responses land
        end
        chk.report_leftovers();
        total = chk.errors + drv_errors;
        $display("errors: %0d total, %0d checker, %0d driver", total, chk.errors, drv_errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // --------------------
    initial begin
        logic ok;
        clk125M    = 1'b0;
        rst_n_i    = 1'b0;
        awaddr_i   = '0;
        awvalid_i  = 1'b0;
        wdata_i    = '0;
        wvalid_i   = 1'b0;
        bready_i   = 1'b1;
        araddr_i   = '0;
        arvalid_i  = 1'b0;
        rready_i   = 1'b1;
        sel_i      = '0;
        s_tvalid_i = '0;
        s_tlast_i  = '0;
        m_tready_i = 1'b0;
        link_i     = '0;
        mdio_i     = 1'b0;
        for (int p = 0; p < `BRIDGE_ETHCOUNT; p++) begin
            s_tdata_i[p] = '0;
            s_tkeep_i[p] = '0;
        end
        lfsr_q = 16'd78;
        load_golden(ok);
        limit = 10 * op_q.size() + 10 * beat_total + 200;
        repeat (3) @(posedge clk125M);
        #1;
        rst_n_i = 1'b1;
        if (!ok) begin
            $display("golden file sim/bridge_golden.txt could not be opened");
            drv_errors++;
        end else begin
            run_golden();
        end
        finish_run();
    end

endmodule

// ==== src.f ====
+incdir+common
common/bridge_pkg.sv
common/reg_if.sv
hw/regs/axil_slave.sv
hw/regs/reg_bank.sv
hw/stream/frame_tx_mux.sv
hw/bridge_top.sv
sim/bridge_checker.sv
sim/tb_bridge.sv
